// File: include/vga_cfg.svh
// VGA sprite subsystem configuration.
// 640x480 timing at a 25 MHz pixel clock, sprite size and colour constants.

`ifndef VGA_CFG_SVH
`define VGA_CFG_SVH

// ==================================================
// Horizontal timing, in pixel clocks
// ==================================================
`define H_ACTIVE 640
`define H_FP 16
`define H_SYNC 96
`define H_TOTAL 800

// ==================================================
// Vertical timing, in lines
// ==================================================
`define V_ACTIVE 480
`define V_FP 10
`define V_SYNC 2
`define V_TOTAL 525

// Sprite and datapath
`define SPRITE_W 48
`define SPRITE_H 64
`define BLANK_RGB 12'h000
`define COORD_W 11
`define DRAW_LATENCY 3

`endif

// File: source/vga_pkg.sv
// VGA sprite shared types.
// Facing and register address enums, plus the fixed sprite pattern.

`include "vga_cfg.svh"

package vga_pkg;

    typedef enum logic {
        facing_right = 1'b0,
        facing_left  = 1'b1
    } facing_t;

    typedef enum logic [1:0] {
        reg_xpos   = 2'd0,
        reg_ypos   = 2'd1,
        reg_facing = 2'd2,
        reg_bg     = 2'd3
    } reg_addr_t;

    // White outline, orange left half, green right half.
    function automatic logic [11:0] sprite_pixel(input int unsigned row, input int unsigned col);
        if (row == 0 || row == `SPRITE_H - 1 || col == 0 || col == `SPRITE_W - 1)
            return 12'hFFF;
        else if (col < `SPRITE_W / 2)
            return 12'hF80;
        else
            return 12'h0F0;
    endfunction

endpackage

// File: source/vga_timing.sv
// VGA timing generator.
// Free-running 800x525 beam counters with registered syncs, blanking
// and a one-cycle pulse at the first pixel of every frame.

`timescale 1ns/1ns

`include "vga_cfg.svh"

module vga_timing (
    input  logic                clk,
    input  logic                rst,
    output logic [`COORD_W-1:0] hcount,
    output logic [`COORD_W-1:0] vcount,
    output logic                hsync,
    output logic                vsync,
    output logic                hblnk,
    output logic                vblnk,
    output logic                frame_start
);

    localparam int unsigned CW      = `COORD_W;
    localparam int unsigned HS_BEG  = `H_ACTIVE + `H_FP;
    localparam int unsigned HS_END  = HS_BEG + `H_SYNC;
    localparam int unsigned VS_BEG  = `V_ACTIVE + `V_FP;
    localparam int unsigned VS_END  = VS_BEG + `V_SYNC;

    logic [CW-1:0] h_nxt;
    logic [CW-1:0] v_nxt;

    // ==================================================
    // Next beam position
    // ==================================================
    always_comb begin
        h_nxt = (hcount == CW'(`H_TOTAL - 1)) ? '0 : hcount + 1'b1;
        v_nxt = vcount;
        if (hcount == CW'(`H_TOTAL - 1)) begin
            v_nxt = (vcount == CW'(`V_TOTAL - 1)) ? '0 : vcount + 1'b1;
        end
    end

    // Decoded outputs are registered together with the counters.
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount      <= '0;
            vcount      <= '0;
            hsync       <= 1'b1;  // Position 0 is outside the sync pulse.
            vsync       <= 1'b1;
            hblnk       <= 1'b0;
            vblnk       <= 1'b0;
            frame_start <= 1'b1;
        end else begin
            hcount      <= h_nxt;
            vcount      <= v_nxt;
            hsync       <= !(h_nxt >= CW'(HS_BEG) && h_nxt < CW'(HS_END));  // Active low.
            vsync       <= !(v_nxt >= CW'(VS_BEG) && v_nxt < CW'(VS_END));
            hblnk       <= (h_nxt >= CW'(`H_ACTIVE));
            vblnk       <= (v_nxt >= CW'(`V_ACTIVE));
            frame_start <= (h_nxt == '0) && (v_nxt == '0);
        end
    end

endmodule

// File: source/delay.sv
// Parametric delay line.
// Shifts a WIDTH-bit bus through CLK_DEL registers (CLK_DEL of 1 or more).

`timescale 1ns/1ns

module delay #(
    parameter int unsigned WIDTH   = 8,
    parameter int unsigned CLK_DEL = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] stage [CLK_DEL];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CLK_DEL; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < CLK_DEL; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[CLK_DEL-1];  // Last tap.

endmodule

// File: source/sprite_rom.sv
// Sprite pixel ROM.
// 64 rows of 64 columns, 48 of them used, with a registered read port.

`timescale 1ns/1ns

`include "vga_cfg.svh"

module sprite_rom (
    input  logic        clk,
    input  logic [11:0] addr,
    output logic [11:0] rgb
);

    import vga_pkg::*;

    logic [11:0] mem [4096];

    // Row in the upper six address bits, column in the lower six.
    initial begin
        for (int r = 0; r < 64; r++) begin
            for (int c = 0; c < 64; c++) begin
                if (r < `SPRITE_H && c < `SPRITE_W)
                    mem[r*64 + c] = sprite_pixel(r, c);
                else
                    mem[r*64 + c] = 12'h000;  // Unused columns.
            end
        end
    end

    always_ff @(posedge clk) begin
        rgb <= mem[addr];  // One cycle read latency.
    end

endmodule

// File: source/draw_sprite.sv
// Sprite drawing stage.
// Looks up the sprite pixel under the beam, optionally mirrored, and
// overlays it on the background colour with the syncs kept aligned.

`timescale 1ns/1ns

`include "vga_cfg.svh"

module draw_sprite (
    input  logic                clk,
    input  logic                rst,
    input  logic [`COORD_W-1:0] hcount,
    input  logic [`COORD_W-1:0] vcount,
    input  logic                hsync,
    input  logic                vsync,
    input  logic                hblnk,
    input  logic                vblnk,
    input  logic [`COORD_W-1:0] xpos,
    input  logic [`COORD_W-1:0] ypos,
    input  vga_pkg::facing_t    facing,
    input  logic [11:0]         bg_rgb,
    output logic [11:0]         rom_addr,
    input  logic [11:0]         rom_rgb,
    output logic [11:0]         rgb,
    output logic                hsync_out,
    output logic                vsync_out
);

    import vga_pkg::*;

    localparam int unsigned CW = `COORD_W;
    localparam int unsigned SW = `SPRITE_W;
    localparam int unsigned SH = `SPRITE_H;

    logic [CW-1:0] hcount_d;
    logic [CW-1:0] vcount_d;
    logic          hsync_d;
    logic          vsync_d;
    logic          hblnk_d;
    logic          vblnk_d;
    logic [CW-1:0] row_off;
    logic [CW-1:0] col_off;
    logic [5:0]    col_sel;
    logic [CW:0]   x_end;
    logic [CW:0]   y_end;
    logic          in_window;
    logic [11:0]   rgb_nxt;

    // Beam signals wait for the address register and the ROM read.
    delay #(
        .WIDTH  (2 * CW + 4),
        .CLK_DEL(2)
    ) u_delay (
        .clk,
        .rst,
        .din ({hcount, vcount, hsync, vsync, hblnk, vblnk}),
        .dout({hcount_d, vcount_d, hsync_d, vsync_d, hblnk_d, vblnk_d})
    );

    // ==================================================
    // Stage 1: ROM address from the live beam position
    // ==================================================
    assign row_off = vcount - ypos;
    assign col_off = hcount - xpos;

    always_comb begin
        if (facing == facing_left)
            col_sel = 6'(SW - 1 - col_off);  // Mirrored column.
        else
            col_sel = col_off[5:0];
    end

    always_ff @(posedge clk) begin
        rom_addr <= {row_off[5:0], col_sel};
    end

    // ==================================================
    // Stage 3: colour select against the delayed beam
    // ==================================================
    assign x_end = {1'b0, xpos} + (CW+1)'(SW);  // One extra bit so the sum cannot wrap.
    assign y_end = {1'b0, ypos} + (CW+1)'(SH);

    assign in_window = (hcount_d >= xpos) && ({1'b0, hcount_d} < x_end) &&
                       (vcount_d >= ypos) && ({1'b0, vcount_d} < y_end);

    always_comb begin
        if (hblnk_d || vblnk_d)
            rgb_nxt = `BLANK_RGB;
        else if (in_window)
            rgb_nxt = rom_rgb;
        else
            rgb_nxt = bg_rgb;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb       <= '0;
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
        end else begin
            rgb       <= rgb_nxt;
            hsync_out <= hsync_d;
            vsync_out <= vsync_d;
        end
    end

endmodule

// File: source/sprite_regs.sv
// Sprite control registers on a Wishbone classic slave.
// Writes go to pending copies that become active at the start of a frame.

`timescale 1ns/1ns

`include "vga_cfg.svh"

module sprite_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [1:0]          wb_adr,
    input  logic [15:0]         wb_dat_w,
    output logic [15:0]         wb_dat_r,
    output logic                wb_ack,
    input  logic                frame_start,
    output logic [`COORD_W-1:0] xpos,
    output logic [`COORD_W-1:0] ypos,
    output vga_pkg::facing_t    facing,
    output logic [11:0]         bg_rgb
);

    import vga_pkg::*;

    localparam int unsigned CW = `COORD_W;

    logic [CW-1:0] xpos_pend;
    logic [CW-1:0] ypos_pend;
    facing_t       facing_pend;
    logic [11:0]   bg_pend;
    logic          req;
    reg_addr_t     addr;

    assign req  = wb_cyc && wb_stb && !wb_ack;  // New strobe, not yet acknowledged.
    assign addr = reg_addr_t'(wb_adr);

    // ==================================================
    // Bus handshake and pending registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack      <= 1'b0;
            xpos_pend   <= '0;
            ypos_pend   <= '0;
            facing_pend <= facing_right;
            bg_pend     <= 12'h000;
        end else begin
            wb_ack <= req;
            if (req && wb_we) begin
                case (addr)
                    reg_xpos:   xpos_pend   <= wb_dat_w[CW-1:0];
                    reg_ypos:   ypos_pend   <= wb_dat_w[CW-1:0];
                    reg_facing: facing_pend <= facing_t'(wb_dat_w[0]);
                    reg_bg:     bg_pend     <= wb_dat_w[11:0];
                    default:    ;
                endcase
            end
        end
    end

    // Read data is captured with the ack.
    always_ff @(posedge clk) begin
        if (req) begin
            case (addr)
                reg_xpos:   wb_dat_r <= 16'(xpos_pend);
                reg_ypos:   wb_dat_r <= 16'(ypos_pend);
                reg_facing: wb_dat_r <= 16'(facing_pend);
                default:    wb_dat_r <= 16'(bg_pend);
            endcase
        end
    end

    // Active copies, updated only at the first pixel of a frame.
    always_ff @(posedge clk) begin
        if (rst) begin
            xpos   <= '0;
            ypos   <= '0;
            facing <= facing_right;
            bg_rgb <= 12'h000;
        end else if (frame_start) begin
            xpos   <= xpos_pend;
            ypos   <= ypos_pend;
            facing <= facing_pend;
            bg_rgb <= bg_pend;
        end
    end

endmodule

// File: source/vga_sprite_top.sv
// VGA sprite subsystem top level.
// Timing generator, register block, sprite stage and sprite ROM.

`timescale 1ns/1ns

`include "vga_cfg.svh"

module vga_sprite_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [15:0] wb_dat_w,
    output logic [15:0] wb_dat_r,
    output logic        wb_ack,
    output logic [11:0] rgb,
    output logic        hsync,
    output logic        vsync
);

    import vga_pkg::*;

    logic [`COORD_W-1:0] hcount;
    logic [`COORD_W-1:0] vcount;
    logic                tim_hsync;
    logic                tim_vsync;
    logic                hblnk;
    logic                vblnk;
    logic                frame_start;
    logic [`COORD_W-1:0] xpos;
    logic [`COORD_W-1:0] ypos;
    facing_t             facing;
    logic [11:0]         bg_rgb;
    logic [11:0]         rom_addr;
    logic [11:0]         rom_rgb;

    vga_timing u_vga_timing (
        .clk,
        .rst,
        .hcount,
        .vcount,
        .hsync      (tim_hsync),
        .vsync      (tim_vsync),
        .hblnk,
        .vblnk,
        .frame_start
    );

    sprite_regs u_sprite_regs (
        .clk,
        .rst,
        .wb_cyc,
        .wb_stb,
        .wb_we,
        .wb_adr,
        .wb_dat_w,
        .wb_dat_r,
        .wb_ack,
        .frame_start,
        .xpos,
        .ypos,
        .facing,
        .bg_rgb
    );

    draw_sprite u_draw_sprite (
        .clk,
        .rst,
        .hcount,
        .vcount,
        .hsync     (tim_hsync),
        .vsync     (tim_vsync),
        .hblnk,
        .vblnk,
        .xpos,
        .ypos,
        .facing,
        .bg_rgb,
        .rom_addr,
        .rom_rgb,
        .rgb,
        .hsync_out (hsync),
        .vsync_out (vsync)
    );

    sprite_rom u_sprite_rom (
        .clk,
        .addr (rom_addr),
        .rgb  (rom_rgb)
    );

endmodule

// File: tb/vga_sprite_assertions.sv
// Protocol assertions for the VGA sprite top level.
// Wishbone ack handshake and blank colour during the sync pulses.

`timescale 1ns/1ns

`include "vga_cfg.svh"

module vga_sprite_assertions (
    input logic        clk,
    input logic        rst,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_ack,
    input logic [11:0] rgb,
    input logic        hsync,
    input logic        vsync
);

    int unsigned fail_count = 0;  // Assertion failures so far.

    // Ack only answers a strobe seen in the previous cycle.
    ack_needs_stb: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
        else begin
            fail_count++;
            $error("wb_ack rose without cyc and stb");
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else begin
            fail_count++;
            $error("wb_ack held longer than one cycle");
        end

    // The pipeline holds reset syncs for the draw latency.
    blank_in_sync: assert property (@(posedge clk) disable iff (rst)
        (!hsync || !vsync) && !$past(rst, 1) && !$past(rst, 2) && !$past(rst, `DRAW_LATENCY)
        |-> rgb == `BLANK_RGB)
        else begin
            fail_count++;
            $error("rgb not blank during a sync pulse");
        end

endmodule

bind vga_sprite_top vga_sprite_assertions u_assertions (
    .clk,
    .rst,
    .wb_cyc,
    .wb_stb,
    .wb_ack,
    .rgb,
    .hsync,
    .vsync
);

// File: tb/vga_sprite_tb.sv
// VGA sprite subsystem testbench.
// Table-driven: writes sprite registers over Wishbone mid-frame and checks
// sync timing and pixel colours against a model of the sprite stage.

`timescale 1ns/1ns

`include "vga_cfg.svh"

module vga_sprite_tb;

    import vga_pkg::*;

    localparam int FRAME     = `H_TOTAL * `V_TOTAL;
    localparam int HS_BEG    = `H_ACTIVE + `H_FP;
    localparam int HS_END    = HS_BEG + `H_SYNC;
    localparam int VS_BEG    = `V_ACTIVE + `V_FP;
    localparam int VS_END    = VS_BEG + `V_SYNC;
    localparam int MID_LINE  = 240;
    localparam int ACK_LIMIT = 8;
    localparam int NUM_ROWS  = 4;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [15:0] wb_dat_w;
    logic [15:0] wb_dat_r;
    logic        wb_ack;
    logic [11:0] rgb;
    logic        hsync;
    logic        vsync;

    // Beam position of the pixel on the DUT outputs.
    int   bx;
    int   by;
    logic h_locked;
    logic v_locked;
    logic hs_prev;
    logic vs_prev;

    // Sprite table: top-left, middle, mirrored, clipped at the right edge.
    int          tbl_x  [NUM_ROWS] = '{0, 296, 296, 620};
    int          tbl_y  [NUM_ROWS] = '{0, 208, 208, 100};
    facing_t     tbl_f  [NUM_ROWS] = '{facing_right, facing_right, facing_left, facing_right};
    logic [11:0] tbl_bg [NUM_ROWS] = '{12'h00F, 12'h123, 12'h345, 12'h0A0};

    // Register access values and the width of each register.
    logic [15:0] acc_val  [4] = '{16'hFFFF, 16'hABCD, 16'h0003, 16'h5A5A};
    logic [15:0] acc_mask [4] = '{16'h07FF, 16'h07FF, 16'h0001, 16'h0FFF};

    vga_sprite_top dut_i (
        .clk,
        .rst,
        .wb_cyc,
        .wb_stb,
        .wb_we,
        .wb_adr,
        .wb_dat_w,
        .wb_dat_r,
        .wb_ack,
        .rgb,
        .hsync,
        .vsync
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period.
    end

    always @(dut_i.u_assertions.fail_count) begin
        if (dut_i.u_assertions.fail_count != 0) begin
            $display("Checks failed");
            $fatal(1);
        end
    end

    // ==================================================
    // Checking helpers
    // ==================================================
    task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("ERR %s got %0h exp %0h", name, act, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out waiting for %s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    function automatic logic hsync_expected(input int h);
        return !(h >= HS_BEG && h < HS_END);
    endfunction

    function automatic logic vsync_expected(input int v);
        return !(v >= VS_BEG && v < VS_END);
    endfunction

    // Outline white, left half orange, right half green.
    function automatic logic [11:0] pattern_colour(input int row, input int col);
        if (row == 0 || row == `SPRITE_H - 1 || col == 0 || col == `SPRITE_W - 1)
            return 12'hFFF;
        if (col < `SPRITE_W / 2)
            return 12'hF80;
        return 12'h0F0;
    endfunction

    function automatic logic [11:0] model_rgb(input int h, input int v, input int x, input int y,
                                              input facing_t f, input logic [11:0] bg);
        int col;
        int row;
        if (h >= `H_ACTIVE || v >= `V_ACTIVE)
            return `BLANK_RGB;
        if (h >= x && h < x + `SPRITE_W && v >= y && v < y + `SPRITE_H) begin
            row = v - y;
            col = h - x;
            if (f == facing_left)
                col = `SPRITE_W - 1 - col;  // Mirrored.
            return pattern_colour(row, col);
        end
        return bg;
    endfunction

    // One cycle; recovers the beam from sync edges, then checks the syncs.
    task automatic tick();
        @(negedge clk);
        if (h_locked) begin
            bx = (bx == `H_TOTAL - 1) ? 0 : bx + 1;
            if (v_locked && bx == 0)
                by = (by == `V_TOTAL - 1) ? 0 : by + 1;
            check_val("hsync", hsync, hsync_expected(bx));
        end else if (hs_prev && !hsync) begin
            h_locked = 1'b1;
            bx = HS_BEG;
        end
        if (v_locked) begin
            check_val("vsync", vsync, vsync_expected(by));
        end else if (h_locked && vs_prev && !vsync) begin
            check_val("hpos_at_vsync_fall", bx, 0);
            v_locked = 1'b1;
            by = VS_BEG;
        end
        hs_prev = hsync;
        vs_prev = vsync;
    endtask

    // ==================================================
    // Wishbone master
    // ==================================================
    task automatic bus_access(input logic we, input logic [1:0] adr, input logic [15:0] wdata,
                              output logic [15:0] rdata);
        int n;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        tick();
        n = 1;
        while (!wb_ack && n < ACK_LIMIT) begin
            tick();
            n++;
        end
        if (!wb_ack)
            timeout_fail("wb_ack");
        check_val("ack_latency", n, 1);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        tick();
        check_val("wb_ack", wb_ack, 0);  // Single-cycle ack.
    endtask

    task automatic write_reg(input logic [1:0] adr, input logic [15:0] data);
        logic [15:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic read_reg(input logic [1:0] adr, output logic [15:0] data);
        bus_access(1'b0, adr, 16'h0000, data);
    endtask

    task automatic wait_frame_start();
        int n;
        n = 0;
        while (!(v_locked && bx == 0 && by == 0) && n < 2 * FRAME) begin
            tick();
            n++;
        end
        if (!(v_locked && bx == 0 && by == 0))
            timeout_fail("the start of a frame");
    endtask

    // Checks the sprite lines plus one random row and one random column.
    task automatic check_span(input int count, input int x, input int y, input facing_t f,
                              input logic [11:0] bg, input int sr, input int sc);
        for (int i = 0; i < count; i++) begin
            if ((by >= y && by < y + `SPRITE_H) || by == sr || bx == sc)
                check_val("rgb", rgb, model_rgb(bx, by, x, y, f, bg));
            tick();
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        int unsigned seed;
        logic [15:0] rd;
        int          cur_x;
        int          cur_y;
        facing_t     cur_f;
        logic [11:0] cur_bg;
        int          sr;
        int          sc;
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = 2'b00;
        wb_dat_w  = 16'h0000;
        bx        = 0;
        by        = 0;
        h_locked  = 1'b0;
        v_locked  = 1'b0;
        hs_prev   = 1'b0;
        vs_prev   = 1'b0;
        seed      = 32'h64bf7284;
        void'($urandom(seed));

        repeat (16) tick();
        check_val("rgb", rgb, 0);
        check_val("hsync", hsync, 0);
        check_val("vsync", vsync, 0);
        check_val("wb_ack", wb_ack, 0);
        rst = 1'b0;

        for (int a = 0; a < 4; a++) begin
            write_reg(2'(a), acc_val[a]);
            read_reg(2'(a), rd);
            check_val("wb_dat_r", rd, acc_val[a] & acc_mask[a]);
        end
        // Back to reset values before the first frame boundary.
        write_reg(reg_xpos, 16'h0000);
        write_reg(reg_ypos, 16'h0000);
        write_reg(reg_facing, 16'h0000);
        write_reg(reg_bg, 16'h0000);

        wait_frame_start();
        cur_x  = 0;
        cur_y  = 0;
        cur_f  = facing_right;
        cur_bg = 12'h000;

        // Each row is written mid-frame and shows up in the frame after.
        for (int k = 0; k < NUM_ROWS; k++) begin
            sr = $urandom % `V_TOTAL;
            sc = $urandom % `H_TOTAL;
            check_span(MID_LINE * `H_TOTAL, cur_x, cur_y, cur_f, cur_bg, sr, sc);
            write_reg(reg_xpos, 16'(tbl_x[k]));
            write_reg(reg_ypos, 16'(tbl_y[k]));
            write_reg(reg_facing, 16'(tbl_f[k]));
            write_reg(reg_bg, 16'(tbl_bg[k]));
            check_span(FRAME - (by * `H_TOTAL + bx), cur_x, cur_y, cur_f, cur_bg, sr, sc);
            cur_x  = tbl_x[k];
            cur_y  = tbl_y[k];
            cur_f  = tbl_f[k];
            cur_bg = tbl_bg[k];
        end
        sr = $urandom % `V_TOTAL;
        sc = $urandom % `H_TOTAL;
        check_span(FRAME, cur_x, cur_y, cur_f, cur_bg, sr, sc);

        if (dut_i.u_assertions.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
source/vga_pkg.sv
source/vga_timing.sv
source/delay.sv
source/sprite_rom.sv
source/draw_sprite.sv
source/sprite_regs.sv
source/vga_sprite_top.sv
tb/vga_sprite_assertions.sv
tb/vga_sprite_tb.sv

// File: Bender.yml
package:
  name: vga_sprite

sources:
  - include_dirs:
      - include
    files:
      - source/vga_pkg.sv
      - source/vga_timing.sv
      - source/delay.sv
      - source/sprite_rom.sv
      - source/draw_sprite.sv
      - source/sprite_regs.sv
      - source/vga_sprite_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - tb/vga_sprite_assertions.sv
      - tb/vga_sprite_tb.sv
